// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_rv_decode_exec -f rv_decode_exec.f
status=0
./obj_dir/Vtb_rv_decode_exec > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "TEST FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
exit 0

// File: rv_decode_exec.f
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_regfile.sv
rv_idu.sv
rv_exu.sv
rv_decode_exec.sv
tb_rv_decode_exec.sv

// File: rv_decode_exec.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode_exec (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        inst_valid_i,
  input  rv_isa_pkg::rv_inst_u        inst_i,
  input  logic [rv_isa_pkg::xlen-1:0] pc_i,
  input  logic                        res_ready_i,
  output logic                        inst_ready_o,
  output logic                        res_valid_o,
  output rv_pipe_pkg::exu_res_t       res_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic            dec_valid;
  dec_pkt_t        dec_pkt;
  logic            exu_ready;
  logic [4:0]      rs1_addr;
  logic [4:0]      rs2_addr;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic            rf_we;
  logic [4:0]      rf_waddr;
  logic [xlen-1:0] rf_wdata;

  rv_idu u_idu (
    .clk          (clk),
    .rst          (rst),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .next_ready_i (exu_ready),
    .inst_ready_o (inst_ready_o),
    .valid_o      (dec_valid),
    .rs1_addr_o   (rs1_addr),
    .rs2_addr_o   (rs2_addr),
    .pkt_o        (dec_pkt)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .we_i       (rf_we),
    .waddr_i    (rf_waddr),
    .wdata_i    (rf_wdata),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  rv_exu u_exu (
    .clk         (clk),
    .rst         (rst),
    .valid_i     (dec_valid),
    .pkt_i       (dec_pkt),
    .res_ready_i (res_ready_i),
    .ready_o     (exu_ready),
    .rf_we_o     (rf_we),
    .rf_waddr_o  (rf_waddr),
    .rf_wdata_o  (rf_wdata),
    .res_valid_o (res_valid_o),
    .res_o       (res_o)
  );

endmodule

`default_nettype wire

// File: rv_decode_exec_tests.hex
// inst pc rd_wen rd wdata next_pc taken mem_ren mem_wen mem_addr
// mem_size store_data illegal ebreak ecall
123450b7 00000100 1 01 12345000 00000104 0 0 0 00000000 5 00000000 0 0 0
67808093 00000104 1 01 12345678 00000108 0 0 0 00000000 0 00000000 0 0 0
00001117 00000108 1 02 00001108 0000010c 0 0 0 00000000 1 00000000 0 0 0
ff000193 0000010c 1 03 fffffff0 00000110 0 0 0 00000000 0 00000000 0 0 0
00300213 00000110 1 04 00000003 00000114 0 0 0 00000000 0 00000000 0 0 0
002082b3 00000114 1 05 12346780 00000118 0 0 0 00000000 0 00000000 0 0 0
40320333 00000118 1 06 00000013 0000011c 0 0 0 00000000 0 00000000 0 0 0
0041a3b3 0000011c 1 07 00000001 00000120 0 0 0 00000000 2 00000000 0 0 0
0041b433 00000120 1 08 00000000 00000124 0 0 0 00000000 3 00000000 0 0 0
0030c4b3 00000124 1 09 edcba988 00000128 0 0 0 00000000 4 00000000 0 0 0
00416533 00000128 1 0a 0000110b 0000012c 0 0 0 00000000 6 00000000 0 0 0
0030f5b3 0000012c 1 0b 12345670 00000130 0 0 0 00000000 7 00000000 0 0 0
00409633 00000130 1 0c 91a2b3c0 00000134 0 0 0 00000000 1 00000000 0 0 0
0041d6b3 00000134 1 0d 1ffffffe 00000138 0 0 0 00000000 5 00000000 0 0 0
4041d733 00000138 1 0e fffffffe 0000013c 0 0 0 00000000 5 00000000 0 0 0
00500013 0000013c 1 00 00000005 00000140 0 0 0 00000000 0 00000000 0 0 0
00800463 00000140 0 00 00000000 00000148 1 0 0 00000148 0 00000000 0 0 0
feb08ee3 00000144 0 00 00000000 00000148 0 0 0 00000140 0 00000000 0 0 0
fe039ee3 00000148 0 00 00000000 00000144 1 0 0 00000144 1 00000000 0 0 0
00109463 0000014c 0 00 00000000 00000150 0 0 0 00000154 1 00000000 0 0 0
0041c463 00000150 0 00 00000000 00000158 1 0 0 00000158 4 00000000 0 0 0
00324463 00000154 0 00 00000000 00000158 0 0 0 0000015c 4 00000000 0 0 0
fe325ee3 00000158 0 00 00000000 00000154 1 0 0 00000154 5 00000000 0 0 0
0041d463 0000015c 0 00 00000000 00000160 0 0 0 00000164 5 00000000 0 0 0
00326463 00000160 0 00 00000000 00000168 1 0 0 00000168 6 00000000 0 0 0
fe41eee3 00000164 0 00 00000000 00000168 0 0 0 00000160 6 00000000 0 0 0
0041f463 00000168 0 00 00000000 00000170 1 0 0 00000170 7 00000000 0 0 0
00707463 0000016c 0 00 00000000 00000170 0 0 0 00000174 7 00000000 0 0 0
0200086f 00000170 1 10 00000174 00000190 1 0 0 00000190 0 00000000 0 0 0
005108e7 00000174 1 11 00000178 0000110c 1 0 0 0000110d 0 00000000 0 0 0
ff882903 00000178 0 00 00000000 0000017c 0 1 0 0000016c 2 00000000 0 0 0
0018a623 0000017c 0 00 00000000 00000180 0 0 1 00000184 2 12345678 0 0 0
ffffffff 00000180 0 00 00000000 00000184 0 0 0 00000000 7 00000000 1 0 0
00000073 00000184 0 00 00000000 00000188 0 0 0 00000000 0 00000000 0 0 1
00100073 00000188 0 00 00000000 0000018c 0 0 0 00000000 0 00000000 0 1 0
011909b3 0000018c 1 13 00000178 00000190 0 0 0 00000000 0 00000000 0 0 0

// File: rv_exu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exu (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        valid_i,
  input  rv_pipe_pkg::dec_pkt_t       pkt_i,
  input  logic                        res_ready_i,
  output logic                        ready_o,
  output logic                        rf_we_o,
  output logic [4:0]                  rf_waddr_o,
  output logic [rv_isa_pkg::xlen-1:0] rf_wdata_o,
  output logic                        res_valid_o,
  output rv_pipe_pkg::exu_res_t       res_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic            accept;
  logic [4:0]      shamt;
  logic [xlen-1:0] alu_res;
  logic [xlen-1:0] target;
  logic [xlen-1:0] next_pc;
  logic            br_taken;
  exu_res_t        res_d;

  assign ready_o = !res_valid_o || res_ready_i;
  assign accept  = valid_i && ready_o;
  assign shamt   = pkt_i.op2[4:0];
  assign target  = pkt_i.jmp_base + pkt_i.jmp_off;

  always_comb begin
    case (pkt_i.alu_op)
      alu_sub:  alu_res = pkt_i.op1 - pkt_i.op2;
      alu_sll:  alu_res = pkt_i.op1 << shamt;
      alu_slt:  alu_res = {31'd0, $signed(pkt_i.op1) < $signed(pkt_i.op2)};
      alu_sltu: alu_res = {31'd0, pkt_i.op1 < pkt_i.op2};
      alu_xor:  alu_res = pkt_i.op1 ^ pkt_i.op2;
      alu_srl:  alu_res = pkt_i.op1 >> shamt;
      alu_sra:  alu_res = $unsigned($signed(pkt_i.op1) >>> shamt);
      alu_or:   alu_res = pkt_i.op1 | pkt_i.op2;
      alu_and:  alu_res = pkt_i.op1 & pkt_i.op2;
      default:  alu_res = pkt_i.op1 + pkt_i.op2;
    endcase
  end

  always_comb begin
    case (pkt_i.funct3)
      f3_beq:  br_taken = pkt_i.op1 == pkt_i.op2;
      f3_bne:  br_taken = pkt_i.op1 != pkt_i.op2;
      f3_blt:  br_taken = $signed(pkt_i.op1) < $signed(pkt_i.op2);
      f3_bge:  br_taken = $signed(pkt_i.op1) >= $signed(pkt_i.op2);
      f3_bltu: br_taken = pkt_i.op1 < pkt_i.op2;
      f3_bgeu: br_taken = pkt_i.op1 >= pkt_i.op2;
      default: br_taken = 1'b0;
    endcase
    br_taken = br_taken && pkt_i.is_branch;
  end

  // jal targets are already even, so clearing bit 0 only matters for jalr.
  always_comb begin
    if (pkt_i.is_jump) next_pc = {target[xlen-1:1], 1'b0};
    else if (br_taken) next_pc = target;
    else next_pc = pkt_i.pc + 32'd4;
  end

  always_comb begin
    res_d            = '0;
    res_d.pc         = pkt_i.pc;
    res_d.rd         = pkt_i.rd;
    res_d.wdata      = pkt_i.rd_wen ? alu_res : '0;
    res_d.rd_wen     = pkt_i.rd_wen;
    res_d.next_pc    = next_pc;
    res_d.taken      = br_taken || pkt_i.is_jump;
    res_d.mem_ren    = pkt_i.mem_ren;
    res_d.mem_wen    = pkt_i.mem_wen;
    res_d.mem_addr   = target;
    res_d.mem_size   = pkt_i.funct3;
    res_d.store_data = pkt_i.store_data;
    res_d.illegal    = pkt_i.illegal;
    res_d.ebreak     = pkt_i.ebreak;
    res_d.ecall      = pkt_i.ecall;
  end

  assign rf_we_o    = accept && pkt_i.rd_wen && pkt_i.rd != 5'd0;
  assign rf_waddr_o = pkt_i.rd;
  assign rf_wdata_o = alu_res;

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid_o <= 1'b0;
    end else if (accept) begin
      res_valid_o <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      res_o <= res_d;
    end
  end

  a_res_stable: assert property (
    @(posedge clk) disable iff (rst)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o)
  );

endmodule

`default_nettype wire

// File: rv_idu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_idu (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        inst_valid_i,
  input  rv_isa_pkg::rv_inst_u        inst_i,
  input  logic [rv_isa_pkg::xlen-1:0] pc_i,
  input  logic [rv_isa_pkg::xlen-1:0] rs1_data_i,
  input  logic [rv_isa_pkg::xlen-1:0] rs2_data_i,
  input  logic                        next_ready_i,
  output logic                        inst_ready_o,
  output logic                        valid_o,
  output logic [4:0]                  rs1_addr_o,
  output logic [4:0]                  rs2_addr_o,
  output rv_pipe_pkg::dec_pkt_t       pkt_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  typedef enum logic {st_idle, st_wait_ready} state_e;

  state_e          state;
  rv_inst_u        inst_q;
  logic [xlen-1:0] pc_q;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= st_idle;
      valid_o      <= 1'b0;
      inst_ready_o <= 1'b1;
    end else begin
      case (state)
        st_idle: if (inst_valid_i) begin
          state        <= st_wait_ready;
          valid_o      <= 1'b1;
          inst_ready_o <= 1'b0;
        end
        st_wait_ready: if (next_ready_i) begin
          state        <= st_idle;
          valid_o      <= 1'b0;
          inst_ready_o <= 1'b1; // next accept one edge after handoff.
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (inst_valid_i && inst_ready_o) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  assign opcode     = inst_q.r.opcode;
  assign funct3     = inst_q.r.funct3;
  assign rs1_addr_o = inst_q.r.rs1;
  assign rs2_addr_o = inst_q.r.rs2;

  assign imm_i = {{20{inst_q.i.imm_11_0[11]}}, inst_q.i.imm_11_0};
  assign imm_s = {{20{inst_q.s.imm_11_5[6]}}, inst_q.s.imm_11_5, inst_q.s.imm_4_0};
  assign imm_b = {{19{inst_q.b.imm_12}}, inst_q.b.imm_12, inst_q.b.imm_11,
                  inst_q.b.imm_10_5, inst_q.b.imm_4_1, 1'b0};
  assign imm_u = {inst_q.u.imm_31_12, 12'b0};
  assign imm_j = {{11{inst_q.j.imm_20}}, inst_q.j.imm_20, inst_q.j.imm_19_12,
                  inst_q.j.imm_11, inst_q.j.imm_10_1, 1'b0};

  always_comb begin
    pkt_o        = '0;
    pkt_o.pc     = pc_q;
    pkt_o.funct3 = funct3;
    pkt_o.alu_op = alu_add;
    pkt_o.op1    = rs1_data_i;
    pkt_o.op2    = rs2_data_i;
    case (opcode)
      op_lui: begin
        pkt_o.op1    = '0;
        pkt_o.op2    = imm_u;
        pkt_o.rd_wen = 1'b1;
      end
      op_auipc: begin
        pkt_o.op1    = pc_q;
        pkt_o.op2    = imm_u;
        pkt_o.rd_wen = 1'b1;
      end
      op_jal, op_jalr: begin
        pkt_o.op1      = pc_q; // link value pc + 4.
        pkt_o.op2      = 32'd4;
        pkt_o.jmp_base = (opcode == op_jalr) ? rs1_data_i : pc_q;
        pkt_o.jmp_off  = (opcode == op_jalr) ? imm_i : imm_j;
        pkt_o.is_jump  = 1'b1;
        pkt_o.rd_wen   = 1'b1;
      end
      op_branch: begin
        pkt_o.jmp_base  = pc_q;
        pkt_o.jmp_off   = imm_b;
        pkt_o.is_branch = 1'b1;
      end
      op_op_imm: begin
        pkt_o.op2    = imm_i;
        pkt_o.alu_op = alu_op_e'({(funct3 == f3_srl) & inst_q.r.funct7[5], funct3});
        pkt_o.rd_wen = 1'b1;
      end
      op_load: begin
        pkt_o.op2      = imm_i;
        pkt_o.jmp_base = rs1_data_i;
        pkt_o.jmp_off  = imm_i;
        pkt_o.mem_ren  = 1'b1;
      end
      op_store: begin
        pkt_o.op2        = imm_s;
        pkt_o.jmp_base   = rs1_data_i;
        pkt_o.jmp_off    = imm_s;
        pkt_o.store_data = rs2_data_i;
        pkt_o.mem_wen    = 1'b1;
      end
      op_op: begin
        pkt_o.alu_op = alu_op_e'({inst_q.r.funct7[5], funct3});
        pkt_o.rd_wen = 1'b1;
      end
      op_system: begin
        if (funct3 == 3'b000 && imm_i == 32'd0) pkt_o.ecall = 1'b1;
        else if (funct3 == 3'b000 && imm_i == 32'd1) pkt_o.ebreak = 1'b1;
        else pkt_o.illegal = 1'b1; // no csr support.
      end
      default: pkt_o.illegal = 1'b1;
    endcase
    if (pkt_o.rd_wen) begin
      pkt_o.rd = inst_q.r.rd;
    end
  end

  a_valid_ready_excl: assert property (
    @(posedge clk) disable iff (rst) !(valid_o && inst_ready_o)
  );

  // regfile must not change under a held packet.
  a_pkt_stable: assert property (
    @(posedge clk) disable iff (rst) valid_o && !next_ready_i |=> $stable(pkt_o)
  );

endmodule

`default_nettype wire

// File: rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  localparam int xlen = 32;

  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_op_imm = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [2:0] f3_srl = 3'b101; // srli and srai share it.

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } rv_inst_u;

endpackage

`default_nettype wire

// File: rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

  // funct7[5] then funct3.
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111,
    alu_sub  = 4'b1000,
    alu_sra  = 4'b1101
  } alu_op_e;

  typedef struct packed {
    logic [rv_isa_pkg::xlen-1:0] pc;
    logic [rv_isa_pkg::xlen-1:0] op1;
    logic [rv_isa_pkg::xlen-1:0] op2;
    logic [rv_isa_pkg::xlen-1:0] jmp_base;
    logic [rv_isa_pkg::xlen-1:0] jmp_off;
    logic [4:0]                  rd;
    alu_op_e                     alu_op;
    logic [2:0]                  funct3; // branch condition or memory size.
    logic [rv_isa_pkg::xlen-1:0] store_data;
    logic                        rd_wen;
    logic                        is_jump;
    logic                        is_branch;
    logic                        mem_ren;
    logic                        mem_wen;
    logic                        illegal;
    logic                        ebreak;
    logic                        ecall;
  } dec_pkt_t;

  typedef struct packed {
    logic [rv_isa_pkg::xlen-1:0] pc;
    logic [4:0]                  rd;
    logic [rv_isa_pkg::xlen-1:0] wdata;
    logic                        rd_wen;
    logic [rv_isa_pkg::xlen-1:0] next_pc;
    logic                        taken;
    logic                        mem_ren;
    logic                        mem_wen;
    logic [rv_isa_pkg::xlen-1:0] mem_addr;
    logic [2:0]                  mem_size;
    logic [rv_isa_pkg::xlen-1:0] store_data;
    logic                        illegal;
    logic                        ebreak;
    logic                        ecall;
  } exu_res_t;

endpackage

`default_nettype wire

// File: rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [4:0]                  rs1_addr_i,
  input  logic [4:0]                  rs2_addr_i,
  input  logic                        we_i,
  input  logic [4:0]                  waddr_i,
  input  logic [rv_isa_pkg::xlen-1:0] wdata_i,
  output logic [rv_isa_pkg::xlen-1:0] rs1_data_o,
  output logic [rv_isa_pkg::xlen-1:0] rs2_data_o
);
  import rv_isa_pkg::*;

  logic [xlen-1:0] regs [1:31]; // x0 has no storage.

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != 5'd0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

  // the execute unit filters rd == 0 before it raises the write.
  a_no_x0_write: assert property (
    @(posedge clk) disable iff (rst) we_i |-> waddr_i != 5'd0
  );

endmodule

`default_nettype wire

// File: tb_rv_decode_exec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decode_exec;
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  localparam int num_tests  = 36;
  localparam int num_fields = 15;
  localparam int max_cycles = num_tests * 20 + 50;

  logic            clk          = 1'b0;
  logic            rst          = 1'b1;
  logic            inst_valid_i = 1'b0;
  rv_inst_u        inst_i       = '0;
  logic [xlen-1:0] pc_i         = '0;
  logic            res_ready_i  = 1'b0;
  logic            inst_ready_o;
  logic            res_valid_o;
  exu_res_t        res_o;

  logic [31:0] tests [0:num_tests*num_fields-1];
  int          sent    = 0;
  int          checked = 0;
  int          errors  = 0;

  rv_decode_exec dut0 (
    .clk          (clk),
    .rst          (rst),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .res_ready_i  (res_ready_i),
    .inst_ready_o (inst_ready_o),
    .res_valid_o  (res_valid_o),
    .res_o        (res_o)
  );

  always #50 clk = ~clk;

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input int idx);
    if (got !== exp) begin
      $display("error: test %0d %s got %h expected %h", idx, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_result(input int idx);
    int base;
    base = idx * num_fields;
    if (idx >= num_tests) begin
      $display("unexpected extra result for pc %h after the last test", res_o.pc);
      errors++;
    end else begin
      compare_field("pc", res_o.pc, tests[base + 1], idx);
      compare_field("rd_wen", 32'(res_o.rd_wen), tests[base + 2], idx);
      compare_field("rd", 32'(res_o.rd), tests[base + 3], idx);
      compare_field("wdata", res_o.wdata, tests[base + 4], idx);
      compare_field("next_pc", res_o.next_pc, tests[base + 5], idx);
      compare_field("taken", 32'(res_o.taken), tests[base + 6], idx);
      compare_field("mem_ren", 32'(res_o.mem_ren), tests[base + 7], idx);
      compare_field("mem_wen", 32'(res_o.mem_wen), tests[base + 8], idx);
      compare_field("mem_addr", res_o.mem_addr, tests[base + 9], idx);
      compare_field("mem_size", 32'(res_o.mem_size), tests[base + 10], idx);
      compare_field("store_data", res_o.store_data, tests[base + 11], idx);
      compare_field("illegal", 32'(res_o.illegal), tests[base + 12], idx);
      compare_field("ebreak", 32'(res_o.ebreak), tests[base + 13], idx);
      compare_field("ecall", 32'(res_o.ecall), tests[base + 14], idx);
    end
  endtask

  // hold each test until the decoder takes it.
  always @(posedge clk) begin
    if (rst) begin
      inst_valid_i <= 1'b0;
      sent         <= 0;
    end else if (inst_valid_i && inst_ready_o) begin
      inst_valid_i <= 1'b0;
      sent         <= sent + 1;
    end else if (sent < num_tests) begin
      inst_valid_i <= 1'b1;
      inst_i       <= tests[sent * num_fields];
      pc_i         <= tests[sent * num_fields + 1];
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      res_ready_i <= 1'b0;
    end else begin
      res_ready_i <= ($urandom % 10) < 7; // about 70% ready.
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      checked <= 0;
    end else if (res_valid_o && res_ready_i) begin
      check_result(checked);
      checked <= checked + 1;
    end
  end

  initial begin
    void'($urandom(19750));
    $readmemh("rv_decode_exec_tests.hex", tests);
    if ($isunknown(tests[num_tests*num_fields-1])) begin
      $display("tests file is missing or shorter than expected");
      errors++;
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    if (inst_ready_o !== 1'b1) begin
      $display("error: inst_ready_o after reset got %h expected 1", inst_ready_o);
      errors++;
    end
    if (res_valid_o !== 1'b0) begin
      $display("error: res_valid_o after reset got %h expected 0", res_valid_o);
      errors++;
    end
    wait (checked == num_tests);
    repeat (10) @(posedge clk); // catch stray results.
    $display("results checked: %0d of %0d, errors: %0d", checked, num_tests, errors);
    if (errors == 0 && checked == num_tests) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (max_cycles) @(posedge clk);
    $display("timeout: handshake stuck, %0d sent and %0d results seen", sent, checked);
    $display("results checked: %0d of %0d, errors: %0d", checked, num_tests, errors);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
